// ==== src/sa_pkg.sv ====
package sa_pkg;

  // Array geometry
  localparam int R = 4;
  localparam int C = 4;

  // Element widths
  localparam int WX = 8;
  localparam int WK = 8;
  localparam int WY = 32;

  // Drain column index width
  localparam int CW = (C > 1) ? $clog2(C) : 1;

  typedef logic signed [WX-1:0] x_elem_t;
  typedef logic signed [WK-1:0] k_elem_t;
  typedef logic signed [WY-1:0] acc_t;

  // Beats per tile
  typedef logic [7:0] len_t;

  typedef logic [CW-1:0] col_idx_t;

  // One pixel per row, one weight per column
  typedef x_elem_t [R-1:0] x_vec_t;
  typedef k_elem_t [C-1:0] k_vec_t;
  typedef acc_t    [R-1:0] y_vec_t;

  // Joined k/x beat into the array
  typedef struct packed {
    x_vec_t x;
    k_vec_t k;
    logic   last;
  } in_beat_t;

  // One drained column of the array
  typedef struct packed {
    y_vec_t data;
    logic   last;
  } col_beat_t;

endpackage

// ==== src/axil_pkg.sv ====
package axil_pkg;

  localparam int AXIL_AW = 8;
  localparam int AXIL_DW = 32;

  typedef logic [AXIL_AW-1:0]   axil_addr_t;
  typedef logic [AXIL_DW-1:0]   axil_data_t;
  typedef logic [AXIL_DW/8-1:0] axil_strb_t;
  typedef logic [1:0]           axil_resp_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

  localparam axil_resp_t resp_okay   = 2'b00;
  localparam axil_resp_t resp_slverr = 2'b10;

  // Register map
  localparam axil_addr_t reg_ctrl       = 8'h00;
  localparam axil_addr_t reg_k_len      = 8'h04;
  localparam axil_addr_t reg_tiles_done = 8'h08;

  // Beats per tile out of reset
  localparam int K_LEN_RESET = 4;

endpackage

// ==== src/axil_regs.sv ====
`timescale 1ns/10ps

module axil_regs
  import sa_pkg::*;
  import axil_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  axil_addr_t aw_addr,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  axil_w_t    w,
  input  logic       w_valid,
  output logic       w_ready,
  output axil_resp_t b_resp,
  output logic       b_valid,
  input  logic       b_ready,
  input  axil_addr_t ar_addr,
  input  logic       ar_valid,
  output logic       ar_ready,
  output axil_data_t r_data,
  output axil_resp_t r_resp,
  output logic       r_valid,
  input  logic       r_ready,
  input  logic       tile_done,
  output logic       enable,
  output len_t       k_len
);

  logic       wr_fire;
  logic       rd_fire;
  len_t       k_len_new;
  axil_data_t tiles_done;
  axil_data_t rd_word;
  axil_resp_t rd_code;

  // Address and data are taken together
  assign wr_fire  = aw_valid & w_valid & ~b_valid;
  assign aw_ready = wr_fire;
  assign w_ready  = wr_fire;

  assign ar_ready = ~r_valid;
  assign rd_fire  = ar_valid & ar_ready;

  // Both writable fields sit in byte lane 0
  assign k_len_new = w.strb[0] ? w.data[$bits(len_t)-1:0] : k_len;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable  <= 1'b0;
      k_len   <= len_t'(K_LEN_RESET);
      b_valid <= 1'b0;
      b_resp  <= resp_okay;
    end else begin
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
      if (wr_fire) begin
        b_valid <= 1'b1;
        b_resp  <= resp_okay;
        case (aw_addr)
          reg_ctrl: begin
            if (w.strb[0]) begin
              enable <= w.data[0];
            end
          end
          reg_k_len: begin
            // Zero-length tiles are refused
            if (k_len_new == '0) begin
              b_resp <= resp_slverr;
            end else begin
              k_len <= k_len_new;
            end
          end
          reg_tiles_done: begin
            // Read-only counter
          end
          default: b_resp <= resp_slverr;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tiles_done <= '0;
    end else if (tile_done) begin
      tiles_done <= tiles_done + axil_data_t'(1);
    end
  end

  always_comb begin
    rd_word = '0;
    rd_code = resp_okay;
    case (ar_addr)
      reg_ctrl:       rd_word = axil_data_t'(enable);
      reg_k_len:      rd_word = axil_data_t'(k_len);
      reg_tiles_done: rd_word = tiles_done;
      default:        rd_code = resp_slverr;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
      r_data  <= '0;
      r_resp  <= resp_okay;
    end else if (rd_fire) begin
      r_valid <= 1'b1;
      r_data  <= rd_word;
      r_resp  <= rd_code;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b_resp));

endmodule

// ==== src/stream_join.sv ====
`timescale 1ns/10ps

module stream_join
  import sa_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  k_vec_t   k_data,
  input  logic     k_valid,
  output logic     k_ready,
  input  x_vec_t   x_data,
  input  logic     x_valid,
  output logic     x_ready,
  input  logic     enable,
  input  len_t     k_len,
  output in_beat_t out_beat,
  output logic     out_valid,
  input  logic     out_ready
);

  logic fire;
  logic last;
  len_t cnt;
  len_t len_q;
  len_t cur_len;

  // Each side waits for the other
  assign out_valid = k_valid & x_valid & enable;
  assign k_ready   = out_ready & x_valid & enable;
  assign x_ready   = out_ready & k_valid & enable;
  assign fire      = out_valid & out_ready;

  // Live length on the first beat, held copy for the rest of the tile
  assign cur_len = (cnt == '0) ? k_len : len_q;
  assign last    = (cnt == cur_len - len_t'(1));

  assign out_beat.x    = x_data;
  assign out_beat.k    = k_data;
  assign out_beat.last = last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      len_q <= '0;
    end else if (fire) begin
      if (cnt == '0) begin
        len_q <= k_len;
      end
      if (last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + len_t'(1);
      end
    end
  end

  a_cnt_in_tile: assert property (@(posedge clk) disable iff (!rst_n)
    cnt != '0 |-> cnt < len_q);

endmodule

// ==== src/mac_array.sv ====
`timescale 1ns/10ps

module mac_array
  import sa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  in_beat_t  in_beat,
  input  logic      in_valid,
  output logic      in_ready,
  output col_beat_t col,
  output logic      col_valid,
  input  logic      col_ready
);

  // Indexed by column, each entry holds R rows
  y_vec_t   acc   [C];
  y_vec_t   drain [C];
  y_vec_t   sum   [C];
  logic     buf_full;
  logic     buf_busy;
  logic     in_fire;
  logic     col_fire;
  col_idx_t col_idx;

  assign col_valid = buf_full;
  assign col.data  = drain[col_idx];
  assign col.last  = (col_idx == col_idx_t'(C - 1));
  assign col_fire  = col_valid & col_ready;

  // Buffer frees up at the same edge its last column leaves
  assign buf_busy = buf_full & ~(col_fire & col.last);
  assign in_ready = ~(in_beat.last & buf_busy);
  assign in_fire  = in_valid & in_ready;

  // Outer product of this beat added to the running sums
  always_comb begin
    for (int c = 0; c < C; c++) begin
      for (int r = 0; r < R; r++) begin
        sum[c][r] = acc[c][r] +
                    acc_t'($signed(in_beat.x[r])) * acc_t'($signed(in_beat.k[c]));
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < C; c++) begin
        acc[c] <= '0;
      end
    end else if (in_fire) begin
      for (int c = 0; c < C; c++) begin
        if (in_beat.last) begin
          acc[c] <= '0;
        end else begin
          acc[c] <= sum[c];
        end
      end
    end
  end

  // Finished tile, including its last beat
  always_ff @(posedge clk) begin
    if (in_fire && in_beat.last) begin
      for (int c = 0; c < C; c++) begin
        drain[c] <= sum[c];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_full <= 1'b0;
      col_idx  <= '0;
    end else begin
      if (col_fire) begin
        if (col.last) begin
          buf_full <= 1'b0;
          col_idx  <= '0;
        end else begin
          col_idx <= col_idx + col_idx_t'(1);
        end
      end
      if (in_fire && in_beat.last) begin
        buf_full <= 1'b1;
      end
    end
  end

  a_col_hold: assert property (@(posedge clk) disable iff (!rst_n)
    col_valid && !col_ready |=> col_valid && $stable(col));

endmodule

// ==== src/psum_adder.sv ====
`timescale 1ns/10ps

module psum_adder
  import sa_pkg::*;
(
  input  col_beat_t col,
  input  logic      col_valid,
  output logic      col_ready,
  input  y_vec_t    a_data,
  input  logic      a_valid,
  output logic      a_ready,
  output y_vec_t    y_data,
  output logic      y_valid,
  output logic      y_last,
  input  logic      y_ready,
  output logic      tile_done
);

  logic y_fire;

  // Column and partial sum move together
  assign y_valid   = col_valid & a_valid;
  assign col_ready = y_ready & a_valid;
  assign a_ready   = y_ready & col_valid;
  assign y_fire    = y_valid & y_ready;

  assign y_last = col.last;

  // Signed add, wraps at WY bits
  always_comb begin
    for (int r = 0; r < R; r++) begin
      y_data[r] = col.data[r] + a_data[r];
    end
  end

  assign tile_done = y_fire & col.last;

endmodule

// ==== src/sa_top.sv ====
`timescale 1ns/10ps

module sa_top
  import sa_pkg::*;
  import axil_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  axil_addr_t aw_addr,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  axil_w_t    w,
  input  logic       w_valid,
  output logic       w_ready,
  output axil_resp_t b_resp,
  output logic       b_valid,
  input  logic       b_ready,
  input  axil_addr_t ar_addr,
  input  logic       ar_valid,
  output logic       ar_ready,
  output axil_data_t r_data,
  output axil_resp_t r_resp,
  output logic       r_valid,
  input  logic       r_ready,
  input  k_vec_t     k_data,
  input  logic       k_valid,
  output logic       k_ready,
  input  x_vec_t     x_data,
  input  logic       x_valid,
  output logic       x_ready,
  input  y_vec_t     a_data,
  input  logic       a_valid,
  output logic       a_ready,
  output y_vec_t     y_data,
  output logic       y_valid,
  output logic       y_last,
  input  logic       y_ready
);

  logic      enable;
  len_t      k_len;
  logic      tile_done;
  in_beat_t  in_beat;
  logic      in_valid;
  logic      in_ready;
  col_beat_t col;
  logic      col_valid;
  logic      col_ready;

  axil_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .aw_addr   (aw_addr),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b_resp    (b_resp),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .ar_addr   (ar_addr),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .r_data    (r_data),
    .r_resp    (r_resp),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .tile_done (tile_done),
    .enable    (enable),
    .k_len     (k_len)
  );

  stream_join u_join (
    .clk       (clk),
    .rst_n     (rst_n),
    .k_data    (k_data),
    .k_valid   (k_valid),
    .k_ready   (k_ready),
    .x_data    (x_data),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .enable    (enable),
    .k_len     (k_len),
    .out_beat  (in_beat),
    .out_valid (in_valid),
    .out_ready (in_ready)
  );

  mac_array u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .col       (col),
    .col_valid (col_valid),
    .col_ready (col_ready)
  );

  psum_adder u_psum (
    .col       (col),
    .col_valid (col_valid),
    .col_ready (col_ready),
    .a_data    (a_data),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .y_data    (y_data),
    .y_valid   (y_valid),
    .y_last    (y_last),
    .y_ready   (y_ready),
    .tile_done (tile_done)
  );

endmodule

// ==== sim/tb_sa_top.sv ====
`timescale 1ns/10ps

module tb_sa_top
  import sa_pkg::*;
  import axil_pkg::*;
();

  // Far above the few hundred cycles all tests take
  localparam int timeout_cycles = 20000;

  logic       clk = 1'b0;
  logic       rst_n;
  axil_addr_t aw_addr;
  logic       aw_valid;
  logic       aw_ready;
  axil_w_t    w;
  logic       w_valid;
  logic       w_ready;
  axil_resp_t b_resp;
  logic       b_valid;
  logic       b_ready;
  axil_addr_t ar_addr;
  logic       ar_valid;
  logic       ar_ready;
  axil_data_t r_data;
  axil_resp_t r_resp;
  logic       r_valid;
  logic       r_ready;
  k_vec_t     k_data;
  logic       k_valid;
  logic       k_ready;
  x_vec_t     x_data;
  logic       x_valid;
  logic       x_ready;
  y_vec_t     a_data;
  logic       a_valid;
  logic       a_ready;
  y_vec_t     y_data;
  logic       y_valid;
  logic       y_last;
  logic       y_ready;

  int          cycles = 0;
  int unsigned lcg_state = 80182;

  sa_top uut (.*);

  always #2 clk = ~clk;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic bit random_bit();
    int unsigned v;
    v = next_rand();
    return v[24];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycles));
    end
  end

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
    @(posedge clk);
    #1;
    aw_addr  = addr;
    aw_valid = 1'b1;
    w.data   = data;
    w.strb   = '1;
    w_valid  = 1'b1;
    do @(negedge clk); while (!aw_ready);
    check("w_ready", w_ready, 1);
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b1;
    do @(negedge clk); while (!b_valid);
    resp = b_resp;
    @(posedge clk);
    #1;
    b_ready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    @(posedge clk);
    #1;
    ar_addr  = addr;
    ar_valid = 1'b1;
    do @(negedge clk); while (!ar_ready);
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    do @(negedge clk); while (!r_valid);
    data = r_data;
    resp = r_resp;
    @(posedge clk);
    #1;
    r_ready = 1'b0;
  endtask

  task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
                              input axil_resp_t exp_resp);
    axil_resp_t resp;
    axil_write(addr, data, resp);
    check($sformatf("b_resp@%02h", addr), resp, exp_resp);
  endtask

  task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
                             input axil_resp_t exp_resp);
    axil_data_t data;
    axil_resp_t resp;
    axil_read(addr, data, resp);
    check($sformatf("r_data@%02h", addr), data, exp_data);
    check($sformatf("r_resp@%02h", addr), resp, exp_resp);
  endtask

  task automatic register_test();
    read_expect(reg_ctrl, 0, resp_okay);
    read_expect(reg_k_len, 4, resp_okay);
    read_expect(reg_tiles_done, 0, resp_okay);
    write_expect(reg_ctrl, 1, resp_okay);
    read_expect(reg_ctrl, 1, resp_okay);
    write_expect(reg_ctrl, 0, resp_okay);
    read_expect(reg_ctrl, 0, resp_okay);
    write_expect(reg_k_len, 7, resp_okay);
    read_expect(reg_k_len, 7, resp_okay);
    // Zero length refused, old value kept
    write_expect(reg_k_len, 0, resp_slverr);
    read_expect(reg_k_len, 7, resp_okay);
    write_expect(reg_tiles_done, 32'h55, resp_okay);
    read_expect(reg_tiles_done, 0, resp_okay);
    write_expect(8'h10, 32'h1, resp_slverr);
    read_expect(8'h0c, 0, resp_slverr);
  endtask

  task automatic disabled_test();
    @(posedge clk);
    #1;
    k_data  = k_vec_t'(next_rand());
    x_data  = x_vec_t'(next_rand());
    a_data  = y_vec_t'(next_rand());
    k_valid = 1'b1;
    x_valid = 1'b1;
    a_valid = 1'b1;
    y_ready = 1'b1;
    repeat (50) begin
      @(negedge clk);
      check("k_ready", k_ready, 0);
      check("x_ready", x_ready, 0);
      check("y_valid", y_valid, 0);
    end
    @(posedge clk);
    #1;
    k_valid = 1'b0;
    x_valid = 1'b0;
    a_valid = 1'b0;
    y_ready = 1'b0;
  endtask

  // Drives n_tiles tiles of len beats, optionally with random stalls
  task automatic run_tiles(input int n_tiles, input int len, input bit stall);
    k_vec_t kq[$];
    x_vec_t xq[$];
    y_vec_t aq[$];
    y_vec_t eq[$];
    y_vec_t av;
    y_vec_t ev;
    int     acc;
    int     n_in;
    int     n_out;
    int     k_idx;
    int     x_idx;
    int     a_idx;
    int     y_idx;
    bit     k_go;
    bit     x_go;
    bit     a_go;
    for (int t = 0; t < n_tiles; t++) begin
      for (int b = 0; b < len; b++) begin
        kq.push_back(k_vec_t'(next_rand()));
        xq.push_back(x_vec_t'(next_rand()));
      end
      // y[c][r] = a[c][r] + sum of x[r]*k[c] over the tile
      for (int c = 0; c < C; c++) begin
        for (int r = 0; r < R; r++) begin
          av[r] = acc_t'(next_rand());
          acc = int'(av[r]);
          for (int b = 0; b < len; b++) begin
            acc += int'($signed(xq[t*len+b][r])) * int'($signed(kq[t*len+b][c]));
          end
          ev[r] = acc_t'(acc);
        end
        aq.push_back(av);
        eq.push_back(ev);
      end
    end
    n_in  = n_tiles * len;
    n_out = n_tiles * C;
    k_idx = 0;
    x_idx = 0;
    a_idx = 0;
    y_idx = 0;
    k_go  = 1'b0;
    x_go  = 1'b0;
    a_go  = 1'b0;
    while (y_idx < n_out) begin
      @(posedge clk);
      #1;
      if (k_go) begin
        k_valid = 1'b0;
      end
      if (x_go) begin
        x_valid = 1'b0;
      end
      if (a_go) begin
        a_valid = 1'b0;
      end
      if (!k_valid && k_idx < n_in && (!stall || random_bit())) begin
        k_valid = 1'b1;
        k_data  = kq[k_idx];
      end
      if (!x_valid && x_idx < n_in && (!stall || random_bit())) begin
        x_valid = 1'b1;
        x_data  = xq[x_idx];
      end
      if (!a_valid && a_idx < n_out && (!stall || random_bit())) begin
        a_valid = 1'b1;
        a_data  = aq[a_idx];
      end
      y_ready = !stall || random_bit();
      @(negedge clk);
      k_go = k_valid && k_ready;
      x_go = x_valid && x_ready;
      a_go = a_valid && a_ready;
      k_idx += int'(k_go);
      x_idx += int'(x_go);
      a_idx += int'(a_go);
      if (y_valid && y_ready) begin
        check("y_data", y_data, eq[y_idx]);
        check("y_last", y_last, (y_idx % C) == C - 1);
        y_idx++;
      end
    end
    @(posedge clk);
    #1;
    k_valid = 1'b0;
    x_valid = 1'b0;
    a_valid = 1'b0;
    y_ready = 1'b0;
    check("k beats taken", k_idx, n_in);
    check("x beats taken", x_idx, n_in);
    check("a beats taken", a_idx, n_out);
  endtask

  initial begin
    rst_n    = 1'b0;
    aw_addr  = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_addr  = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    k_data   = '0;
    k_valid  = 1'b0;
    x_data   = '0;
    x_valid  = 1'b0;
    a_data   = '0;
    a_valid  = 1'b0;
    y_ready  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    register_test();
    disabled_test();

    // Single tile of three beats
    write_expect(reg_k_len, 3, resp_okay);
    write_expect(reg_ctrl, 1, resp_okay);
    run_tiles(1, 3, 1'b0);

    // Three tiles under random stalls
    write_expect(reg_k_len, 5, resp_okay);
    run_tiles(3, 5, 1'b1);

    read_expect(reg_tiles_done, 4, resp_okay);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== list.f ====
src/sa_pkg.sv
src/axil_pkg.sv
src/axil_regs.sv
src/stream_join.sv
src/mac_array.sv
src/psum_adder.sv
src/sa_top.sv
sim/tb_sa_top.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_sa_top
FILELIST := list.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
